/* all.f */
+incdir+tests
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/mips_core.sv
tests/tb_mips_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_mips_core
FILELIST  = all.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
PASS_TEXT = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* tests/mips_model.svh */
// Instruction encoders, random program generator and instruction-level reference model
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

// --------------------
// Encoders
// --------------------
function automatic logic [31:0] enc_r(logic [5:0] fn, int rd, int rs, int rt);
  return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(logic [5:0] op, int rt, int rs, int imm);
  return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic void emit(logic [31:0] word);
  rom[prog_len] = word;
  prog_len++;
endfunction

function automatic void emit_nops(int n);
  for (int i = 0; i < n; i++) begin
    emit(32'h0);
  end
endfunction

function automatic void clear_program();
  for (int i = 0; i < rom_words; i++) begin
    rom[i] = 32'h0;
  end
  prog_len = 0;
endfunction

// Register dump r1..r7, then spin on a self branch
function automatic void emit_epilogue();
  for (int r = 1; r <= 7; r++) begin
    emit(enc_i(op_sw, r, 0, dump_base + 4 * r));
  end
  emit(loop_word);
endfunction

// --------------------
// Random programs
// --------------------
function automatic int pick(int n);
  return $unsigned($random(seed)) % n;
endfunction

function automatic void gen_random_program(int n_body);
  logic [5:0] fns [5];
  int         rd;
  int         rs;
  int         rt;
  int         room;
  fns = '{fn_addu, fn_subu, fn_and, fn_or, fn_slt};
  for (int i = 0; i < n_body; i++) begin
    rd = 1 + pick(7);
    rs = 1 + pick(7);
    rt = 1 + pick(7);
    // Words left before the dump, bounds the branch offset
    room = n_body - 1 - i;
    case (pick(10))
      0, 1, 2: emit(enc_r(fns[pick(5)], rd, rs, rt));
      3:       emit(enc_i(op_addiu, rd, rs, pick(512) - 256));
      4:       emit(enc_i(op_addiu, rd, 0, pick(65536) - 32768));
      5, 6:    emit(enc_i(op_lw, rd, 0, 4 * pick(64)));
      7:       emit(enc_i(op_sw, rt, 0, 4 * pick(64)));
      8:       emit(enc_i(op_beq, rt, rs, (room > 3) ? 1 + pick(3) : room));
      default: emit(32'h0);
    endcase
  end
  emit_epilogue();
endfunction

// --------------------
// Reference model
// --------------------
// One instruction per step, no delay slot
function automatic void run_model();
  logic [31:0] pc;
  logic [31:0] inst;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm;
  logic [31:0] adr;
  store_t      st;
  int          steps;
  for (int r = 0; r < 32; r++) begin
    model_regs[r] = '0;
  end
  for (int i = 0; i < ram_words; i++) begin
    model_ram[i] = ram_pattern(i);
  end
  expected.delete();
  expected_loads = 0;
  pc    = '0;
  steps = 0;
  inst  = rom[pc[8:2]];
  while (inst != loop_word && steps < step_limit) begin
    a   = model_regs[inst[25:21]];
    b   = model_regs[inst[20:16]];
    imm = {{16{inst[15]}}, inst[15:0]};
    adr = a + imm;
    pc  = pc + 32'd4;
    case (inst[31:26])
      op_rtype: begin
        case (inst[5:0])
          fn_addu: model_regs[inst[15:11]] = a + b;
          fn_subu: model_regs[inst[15:11]] = a - b;
          fn_and:  model_regs[inst[15:11]] = a & b;
          fn_or:   model_regs[inst[15:11]] = a | b;
          fn_slt:  model_regs[inst[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: begin
          end
        endcase
      end
      op_addiu: model_regs[inst[20:16]] = adr;
      op_lw: begin
        model_regs[inst[20:16]] = model_ram[adr[7:2]];
        expected_loads++;
      end
      op_sw: begin
        model_ram[adr[7:2]] = b;
        st.adr  = adr;
        st.data = b;
        expected.push_back(st);
      end
      op_beq: begin
        // Offset counts words past the next instruction
        if (a == b) begin
          pc = pc + (imm << 2);
        end
      end
      default: begin
      end
    endcase
    model_regs[0] = '0;
    steps++;
    inst = rom[pc[8:2]];
  end
endfunction

`endif

/* tests/tb_mips_core.sv */
// Testbench for the MIPS core with clock, reset, ROM and RAM models, store checker and watchdog
`timescale 1ns/1ps

module tb_mips_core
  import mips_pkg::*;
();

  localparam int          seed_init    = 47;
  localparam int          clk_period   = 100;
  localparam int          drive_delay  = 5;
  localparam int          reset_cycles = 10;
  localparam int          drain_cycles = 10;
  localparam int          rom_words    = 128;
  localparam int          ram_words    = 64;
  localparam int          body_len     = 52;
  // Body, seven dump stores and the end loop
  localparam int          prog_max     = 60;
  localparam int          num_random   = 4;
  localparam int          num_programs = 3 + num_random;
  localparam int          step_limit   = 4096;
  localparam int          dump_base    = 224;
  localparam logic [31:0] loop_word    = 32'h1000_ffff;
  localparam int          timeout_ns   = num_programs * (prog_max * 10 + reset_cycles) * clk_period;

  typedef struct packed {
    logic [data_width-1:0] adr;
    logic [data_width-1:0] data;
  } store_t;

  logic                  clk;
  logic                  reset;
  logic [data_width-1:0] inst_rom;
  logic [data_width-1:0] ram_word;
  logic [data_width-1:0] pc_rom;
  logic [data_width-1:0] ram_adr;
  logic [data_width-1:0] ram_data;
  logic                  ram_read;
  logic                  ram_write;

  // Program image and memories
  logic [data_width-1:0] rom [rom_words];
  logic [data_width-1:0] ram [ram_words];
  logic [data_width-1:0] model_regs [32];
  logic [data_width-1:0] model_ram [ram_words];
  store_t                expected [$];
  int                    expected_loads;
  int                    reads_seen;
  int                    prog_len;
  int                    seed;
  logic                  checking;

  // Power-on RAM contents, distinct per word
  function automatic logic [31:0] ram_pattern(int i);
    return 32'hc0de_0000 ^ (32'(i) * 32'h0004_0101);
  endfunction

  `include "mips_model.svh"

  // --------------------
  // Directed programs
  // --------------------
  // Independent ALU ops on two constants
  function automatic void build_alu_program();
    emit(enc_i(op_addiu, 1, 0, 1234));
    emit(enc_i(op_addiu, 2, 0, -300));
    emit_nops(3);
    emit(enc_r(fn_addu, 3, 1, 2));
    emit(enc_r(fn_subu, 4, 1, 2));
    emit(enc_r(fn_and, 5, 1, 2));
    emit(enc_r(fn_or, 6, 1, 2));
    emit(enc_r(fn_slt, 7, 2, 1));
    emit_nops(3);
    emit_epilogue();
  endfunction

  // Each result feeds the next one or two
  function automatic void build_forward_program();
    emit(enc_i(op_addiu, 1, 0, 7));
    emit(enc_i(op_addiu, 2, 1, 3));
    emit(enc_r(fn_addu, 3, 1, 2));
    emit(enc_r(fn_subu, 4, 3, 1));
    emit(enc_r(fn_or, 5, 4, 3));
    emit(enc_r(fn_and, 6, 5, 2));
    emit(enc_r(fn_slt, 7, 4, 6));
    emit(enc_i(op_addiu, 1, 7, -9));
    emit(enc_r(fn_addu, 2, 1, 1));
    emit_epilogue();
  endfunction

  // Load-use on rs, rt, store data and a branch, plus taken and not-taken beq
  function automatic void build_load_branch_program();
    emit(enc_i(op_addiu, 1, 0, 'h55));
    emit(enc_i(op_sw, 1, 0, 16));
    emit(enc_i(op_lw, 2, 0, 16));
    emit(enc_r(fn_addu, 3, 2, 1));
    emit(enc_i(op_lw, 4, 0, 40));
    emit(enc_r(fn_subu, 5, 1, 4));
    emit(enc_i(op_lw, 6, 0, 16));
    emit(enc_i(op_sw, 6, 0, 20));
    emit(enc_i(op_beq, 2, 1, 2));
    emit(enc_i(op_addiu, 7, 0, 1));
    emit(enc_i(op_addiu, 3, 0, 2));
    emit(enc_i(op_beq, 4, 1, 1));
    emit(enc_i(op_addiu, 7, 7, 5));
    emit(enc_i(op_beq, 0, 0, 0));
    emit(enc_i(op_lw, 1, 0, 20));
    emit(enc_i(op_beq, 6, 1, 1));
    emit(enc_i(op_addiu, 6, 0, 77));
    emit_epilogue();
  endfunction

  mips_core UUT (
    .clk       (clk),
    .reset     (reset),
    .inst_rom  (inst_rom),
    .ram_word  (ram_word),
    .pc_rom    (pc_rom),
    .ram_adr   (ram_adr),
    .ram_data  (ram_data),
    .ram_read  (ram_read),
    .ram_write (ram_write)
  );

  // --------------------
  // Clock, ROM and RAM
  // --------------------
  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  assign inst_rom = rom[pc_rom[8:2]];
  assign ram_word = ram_read ? ram[ram_adr[7:2]] : '0;

  // Reloaded while the core is held in reset
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < ram_words; i++) begin
        ram[i] <= ram_pattern(i);
      end
    end else if (ram_write === 1'b1) begin
      ram[ram_adr[7:2]] <= ram_data;
    end
  end

  // --------------------
  // Checks
  // --------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_store(input logic [data_width-1:0] adr, input logic [data_width-1:0] data);
    store_t exp;
    if (expected.size() == 0) begin
      report_failure($sformatf("store to %h at %0t with no store left to expect", adr, $time));
    end else begin
      exp = expected.pop_front();
      if (adr !== exp.adr) begin
        report_failure($sformatf("ERROR %0t ram_adr got %h expected %h", $time, adr, exp.adr));
      end else if (data !== exp.data) begin
        report_failure($sformatf("ERROR %0t ram_data got %h expected %h", $time, data, exp.data));
      end
    end
  endtask

  task automatic check_word(input int idx, input logic [data_width-1:0] got,
                            input logic [data_width-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR %0t ram[%0d] got %h expected %h", $time, idx, got, exp));
    end
  endtask

  task automatic check_pc(input logic [data_width-1:0] got);
    if (got !== '0) begin
      report_failure($sformatf("ERROR %0t pc_rom got %h expected %h", $time, got, 32'h0));
    end
  endtask

  // One ram_read cycle per executed load
  task automatic check_reads(input int got, input int exp);
    if (got != exp) begin
      report_failure($sformatf("ERROR %0t ram_read cycles got %0d expected %0d",
                               $time, got, exp));
    end
  endtask

  // Mid-cycle sampling of the store and load strobes
  always @(negedge clk) begin
    if (checking) begin
      if (ram_write !== 1'b0 && ram_write !== 1'b1) begin
        report_failure("ram_write is unknown after reset was released");
      end else if (ram_read !== 1'b0 && ram_read !== 1'b1) begin
        report_failure("ram_read is unknown after reset was released");
      end else begin
        if (ram_read) begin
          reads_seen++;
        end
        if (ram_write) begin
          check_store(ram_adr, ram_data);
        end
      end
    end
  end

  initial begin
    #(timeout_ns);
    report_failure("watchdog expired before all expected stores were seen");
  end

  // --------------------
  // Test sequence
  // --------------------
  task automatic run_program(input string name, input int kind);
    int n_stores;
    checking = 1'b0;
    @(posedge clk);
    #(drive_delay);
    reset = 1'b1;
    clear_program();
    case (kind)
      0:       build_alu_program();
      1:       build_forward_program();
      2:       build_load_branch_program();
      default: gen_random_program(body_len);
    endcase
    run_model();
    n_stores = expected.size();
    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    reset      = 1'b0;
    reads_seen = 0;
    checking   = 1'b1;
    // First cycle out of reset fetches address zero
    @(negedge clk);
    check_pc(pc_rom);
    while (expected.size() != 0) begin
      @(posedge clk);
    end
    // Spinning on the end loop, any further store is an error
    repeat (drain_cycles) @(posedge clk);
    #(drive_delay);
    check_reads(reads_seen, expected_loads);
    for (int i = 0; i < ram_words; i++) begin
      check_word(i, ram[i], model_ram[i]);
    end
    $display("%s: %0d stores and %0d RAM words match", name, n_stores, ram_words);
  endtask

  initial begin
    reset          = 1'b1;
    checking       = 1'b0;
    seed           = seed_init;
    prog_len       = 0;
    reads_seen     = 0;
    expected_loads = 0;
    run_program("alu", 0);
    run_program("forwarding", 1);
    run_program("load-use and branches", 2);
    for (int p = 0; p < num_random; p++) begin
      run_program($sformatf("random %0d", p), 3);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

/* rtl/mips_core.sv */
// Pipelined MIPS core top level wiring stages and hazard unit to ROM and RAM ports
`timescale 1ns/1ps

module mips_core
  import mips_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic [data_width-1:0] inst_rom,
  input  logic [data_width-1:0] ram_word,
  output logic [data_width-1:0] pc_rom,
  output logic [data_width-1:0] ram_adr,
  output logic [data_width-1:0] ram_data,
  output logic                  ram_read,
  output logic                  ram_write
);

  // Fetch to decode
  logic [data_width-1:0]     if_inst;
  logic [data_width-1:0]     if_pc_plus4;

  // Stage registers
  id_ex_t                    id_ex;
  ex_mem_t                   ex_mem;
  mem_wb_t                   wb;

  // Hazard and branch control
  logic [reg_addr_width-1:0] id_rs;
  logic [reg_addr_width-1:0] id_rt;
  logic                      stall;
  logic                      flush;
  logic [1:0]                forward_a;
  logic [1:0]                forward_b;
  logic                      branch_taken;
  logic [data_width-1:0]     branch_target;

  fetch_stage u_fetch (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .flush         (flush),
    .branch_taken  (branch_taken),
    .branch_target (branch_target),
    .inst_rom      (inst_rom),
    .pc_rom        (pc_rom),
    .inst          (if_inst),
    .pc_plus4      (if_pc_plus4)
  );

  decode_stage u_decode (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .flush    (flush),
    .inst     (if_inst),
    .pc_plus4 (if_pc_plus4),
    .wb       (wb),
    .rs       (id_rs),
    .rt       (id_rt),
    .id_ex    (id_ex)
  );

  hazard_unit u_hazard (
    .rs           (id_rs),
    .rt           (id_rt),
    .id_ex        (id_ex),
    .ex_mem       (ex_mem),
    .wb           (wb),
    .branch_taken (branch_taken),
    .stall        (stall),
    .flush        (flush),
    .forward_a    (forward_a),
    .forward_b    (forward_b)
  );

  execute_stage u_execute (
    .clk           (clk),
    .reset         (reset),
    .id_ex         (id_ex),
    .forward_a     (forward_a),
    .forward_b     (forward_b),
    .wb            (wb),
    .ex_mem        (ex_mem),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  memory_stage u_memory (
    .clk       (clk),
    .reset     (reset),
    .ex_mem    (ex_mem),
    .ram_word  (ram_word),
    .ram_adr   (ram_adr),
    .ram_data  (ram_data),
    .ram_read  (ram_read),
    .ram_write (ram_write),
    .wb        (wb)
  );

endmodule

/* rtl/memory_stage.sv */
// Data RAM port, memory/write-back register and write-back value select
`timescale 1ns/1ps

module memory_stage
  import mips_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  ex_mem_t               ex_mem,
  input  logic [data_width-1:0] ram_word,
  output logic [data_width-1:0] ram_adr,
  output logic [data_width-1:0] ram_data,
  output logic                  ram_read,
  output logic                  ram_write,
  output mem_wb_t               wb
);

  mem_wb_t wb_next;

  // RAM port straight from ex_mem, write strobe lasts this one cycle
  assign ram_adr   = ex_mem.alu_result;
  assign ram_data  = ex_mem.store_data;
  assign ram_read  = ex_mem.ctrl.mem_read;
  assign ram_write = ex_mem.ctrl.mem_write;

  // Loaded word or ALU result
  always_comb begin
    wb_next.reg_write  = ex_mem.ctrl.reg_write;
    wb_next.dest       = ex_mem.dest;
    wb_next.write_data = ex_mem.ctrl.mem_to_reg ? ram_word : ex_mem.alu_result;
  end

  always_ff @(posedge clk) begin
    wb <= wb_next;
    if (reset) begin
      wb.reg_write <= 1'b0;
    end
  end

endmodule

/* rtl/execute_stage.sv */
// Operand forwarding, ALU, beq compare and target, execute/memory register
`timescale 1ns/1ps

module execute_stage
  import mips_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  id_ex_t                id_ex,
  input  logic [1:0]            forward_a,
  input  logic [1:0]            forward_b,
  input  mem_wb_t               wb,
  output ex_mem_t               ex_mem,
  output logic                  branch_taken,
  output logic [data_width-1:0] branch_target
);

  logic [data_width-1:0] op_a;
  logic [data_width-1:0] rt_value;
  logic [data_width-1:0] op_b;
  logic [data_width-1:0] alu_result;
  ex_mem_t               ex_mem_next;

  // --------------------
  // Forwarding
  // --------------------
  always_comb begin
    case (forward_a)
      2'b10:   op_a = ex_mem.alu_result;
      2'b01:   op_a = wb.write_data;
      default: op_a = id_ex.data_1;
    endcase

    case (forward_b)
      2'b10:   rt_value = ex_mem.alu_result;
      2'b01:   rt_value = wb.write_data;
      default: rt_value = id_ex.data_2;
    endcase
  end

  // Immediate replaces rt for addiu, lw, sw
  assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : rt_value;

  // --------------------
  // ALU
  // --------------------
  always_comb begin
    case (id_ex.ctrl.alu_op)
      alu_add: alu_result = op_a + op_b;
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_slt: alu_result = {{(data_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_result = '0;
    endcase
  end

  // beq on forwarded operands, offset in words
  assign branch_taken  = id_ex.ctrl.branch && (op_a == rt_value);
  assign branch_target = id_ex.pc_plus4 + {id_ex.imm[data_width-3:0], 2'b00};

  // --------------------
  // Execute/memory register
  // --------------------
  always_comb begin
    ex_mem_next.ctrl       = id_ex.ctrl;
    ex_mem_next.alu_result = alu_result;
    ex_mem_next.store_data = rt_value;
    ex_mem_next.dest       = id_ex.dest;
  end

  always_ff @(posedge clk) begin
    ex_mem <= ex_mem_next;
    if (reset) begin
      ex_mem.ctrl <= '0;
    end
  end

endmodule

/* rtl/hazard_unit.sv */
// Load-use stall, branch flush and forwarding select logic
`timescale 1ns/1ps

module hazard_unit
  import mips_pkg::*;
(
  input  logic [reg_addr_width-1:0] rs,
  input  logic [reg_addr_width-1:0] rt,
  input  id_ex_t                    id_ex,
  input  ex_mem_t                   ex_mem,
  input  mem_wb_t                   wb,
  input  logic                      branch_taken,
  output logic                      stall,
  output logic                      flush,
  output logic [1:0]                forward_a,
  output logic [1:0]                forward_b
);

  logic ex_mem_fwd;
  logic wb_fwd;

  // Load in execute feeding decode, hold one cycle
  assign stall = id_ex.ctrl.mem_read && (id_ex.dest != '0) &&
                 ((id_ex.dest == rs) || (id_ex.dest == rt));

  // Two younger instructions dropped
  assign flush = branch_taken;

  // Producers that actually write a real register
  assign ex_mem_fwd = ex_mem.ctrl.reg_write && (ex_mem.dest != '0);
  assign wb_fwd     = wb.reg_write && (wb.dest != '0);

  // 2'b10 from ex_mem, 2'b01 from wb, 2'b00 register file
  always_comb begin
    forward_a = 2'b00;
    if (ex_mem_fwd && ex_mem.dest == id_ex.rs) begin
      forward_a = 2'b10;
    end else if (wb_fwd && wb.dest == id_ex.rs) begin
      forward_a = 2'b01;
    end

    forward_b = 2'b00;
    if (ex_mem_fwd && ex_mem.dest == id_ex.rt) begin
      forward_b = 2'b10;
    end else if (wb_fwd && wb.dest == id_ex.rt) begin
      forward_b = 2'b01;
    end
  end

endmodule

/* rtl/decode_stage.sv */
// Instruction decode, control word, immediate extension, register read and decode/execute register
`timescale 1ns/1ps

module decode_stage
  import mips_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stall,
  input  logic                      flush,
  input  logic [data_width-1:0]     inst,
  input  logic [data_width-1:0]     pc_plus4,
  input  mem_wb_t                   wb,
  output logic [reg_addr_width-1:0] rs,
  output logic [reg_addr_width-1:0] rt,
  output id_ex_t                    id_ex
);

  logic [5:0]                opcode;
  logic [5:0]                funct;
  logic [reg_addr_width-1:0] rd;
  logic [data_width-1:0]     data_1;
  logic [data_width-1:0]     data_2;
  ctrl_t                     ctrl;
  logic [reg_addr_width-1:0] dest;
  id_ex_t                    id_ex_next;

  // --------------------
  // Field split
  // --------------------
  assign opcode = inst[31:26];
  assign rs     = inst[25:21];
  assign rt     = inst[20:16];
  assign rd     = inst[15:11];
  assign funct  = inst[5:0];

  register_file u_register_file (
    .clk    (clk),
    .reset  (reset),
    .rs     (rs),
    .rt     (rt),
    .wb     (wb),
    .data_1 (data_1),
    .data_2 (data_2)
  );

  // --------------------
  // Control word
  // --------------------
  always_comb begin
    // Anything not listed below stays a no-op
    ctrl = '0;
    dest = '0;
    unique case (opcode)
      op_rtype: begin
        dest           = rd;
        ctrl.reg_write = 1'b1;
        case (funct)
          fn_addu: ctrl.alu_op = alu_add;
          fn_subu: ctrl.alu_op = alu_sub;
          fn_and:  ctrl.alu_op = alu_and;
          fn_or:   ctrl.alu_op = alu_or;
          fn_slt:  ctrl.alu_op = alu_slt;
          default: begin
            // Includes the all-zero word
            ctrl.reg_write = 1'b0;
            dest           = '0;
          end
        endcase
      end
      op_addiu: begin
        dest             = rt;
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_add;
      end
      op_lw: begin
        dest             = rt;
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_add;
      end
      op_sw: begin
        // Address from base plus offset
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_add;
      end
      op_beq: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = alu_sub;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

  // --------------------
  // Decode/execute register
  // --------------------
  always_comb begin
    id_ex_next.ctrl     = ctrl;
    id_ex_next.pc_plus4 = pc_plus4;
    id_ex_next.data_1   = data_1;
    id_ex_next.data_2   = data_2;
    // Sign-extended 16-bit immediate
    id_ex_next.imm      = {{(data_width-16){inst[15]}}, inst[15:0]};
    id_ex_next.rs       = rs;
    id_ex_next.rt       = rt;
    id_ex_next.dest     = dest;
  end

  // Bubble on stall or flush, payload follows regardless
  always_ff @(posedge clk) begin
    id_ex <= id_ex_next;
    if (reset || stall || flush) begin
      id_ex.ctrl <= '0;
    end
  end

endmodule

/* rtl/register_file.sv */
// 32-entry register file, two read ports, one write port, zero register, write bypass
`timescale 1ns/1ps

module register_file
  import mips_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic [reg_addr_width-1:0] rs,
  input  logic [reg_addr_width-1:0] rt,
  input  mem_wb_t                   wb,
  output logic [data_width-1:0]     data_1,
  output logic [data_width-1:0]     data_2
);

  logic [data_width-1:0] regs [2**reg_addr_width];
  logic                  wr_en;

  // Writes to r0 are dropped
  assign wr_en = wb.reg_write && (wb.dest != '0);

  // Architectural state starts from zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**reg_addr_width; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.dest] <= wb.write_data;
    end
  end

  // Same-cycle write is visible to decode
  always_comb begin
    if (rs == '0)                  data_1 = '0;
    else if (wr_en && wb.dest == rs) data_1 = wb.write_data;
    else                           data_1 = regs[rs];

    if (rt == '0)                  data_2 = '0;
    else if (wr_en && wb.dest == rt) data_2 = wb.write_data;
    else                           data_2 = regs[rt];
  end

endmodule

/* rtl/fetch_stage.sv */
// Program counter and fetch/decode register with stall and branch flush
`timescale 1ns/1ps

module fetch_stage
  import mips_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stall,
  input  logic                  flush,
  input  logic                  branch_taken,
  input  logic [data_width-1:0] branch_target,
  input  logic [data_width-1:0] inst_rom,
  output logic [data_width-1:0] pc_rom,
  output logic [data_width-1:0] inst,
  output logic [data_width-1:0] pc_plus4
);

  logic [data_width-1:0] pc;
  logic [data_width-1:0] pc_next;

  assign pc_next = pc + data_width'(4);
  assign pc_rom  = pc;

  // Taken branch wins over a stall
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc_next;
    end
  end

  // Decode slot, a flushed slot holds the all-zero no-op
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      inst     <= '0;
      pc_plus4 <= '0;
    end else if (!stall) begin
      inst     <= inst_rom;
      pc_plus4 <= pc_next;
    end
  end

endmodule

/* rtl/mips_pkg.sv */
// Word and register widths, MIPS opcodes and function codes, ALU operations, stage-register structs

package mips_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int data_width     = 32;
  localparam int reg_addr_width = 5;

  // --------------------
  // Encodings
  // --------------------
  // Primary opcodes, bits 31:26
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;
  localparam logic [5:0] op_beq   = 6'h04;

  // R-type function codes, bits 5:0
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_slt  = 6'h2a;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_t;

  // --------------------
  // Stage registers
  // --------------------
  // Control word, all zero is a bubble
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    alu_src_imm;
    logic    branch;
    alu_op_t alu_op;
  } ctrl_t;

  // Decode to execute
  typedef struct packed {
    ctrl_t                     ctrl;
    logic [data_width-1:0]     pc_plus4;
    logic [data_width-1:0]     data_1;
    logic [data_width-1:0]     data_2;
    logic [data_width-1:0]     imm;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] dest;
  } id_ex_t;

  // Execute to memory
  typedef struct packed {
    ctrl_t                     ctrl;
    logic [data_width-1:0]     alu_result;
    logic [data_width-1:0]     store_data;
    logic [reg_addr_width-1:0] dest;
  } ex_mem_t;

  // Memory to write-back, also the register file write port
  typedef struct packed {
    logic                      reg_write;
    logic [reg_addr_width-1:0] dest;
    logic [data_width-1:0]     write_data;
  } mem_wb_t;

endpackage
